// ==== hw/game_pkg.sv ====
// game rules: state encoding, scan keycodes, background ids and health sizing; health fits HEALTH_W bits
package game_pkg;

	// game flow states, 3-bit encoded
	typedef enum logic [2:0]
	{
		Menu,
		Round_Paused,
		Round_Started,
		Blue_Wins,
		Red_Wins
	} game_state_t;

	// keyboard scan codes, one key at a time
	localparam logic [7:0] KEY_SELECT     = 8'h28;
	localparam logic [7:0] KEY_UP_W       = 8'h1A;
	localparam logic [7:0] KEY_UP_ARROW   = 8'h52;
	localparam logic [7:0] KEY_DOWN_S     = 8'h16;
	localparam logic [7:0] KEY_DOWN_ARROW = 8'h51;

	// background ids
	localparam int BG_W = 2;

	// arena maps selectable from the menu
	localparam logic [BG_W-1:0] MAP_FIRST = 2'd0;
	localparam logic [BG_W-1:0] MAP_LAST  = 2'd1;

	// win screens
	localparam logic [BG_W-1:0] BG_BLUE_WIN = 2'd2;
	localparam logic [BG_W-1:0] BG_RED_WIN  = 2'd3;

	// player health
	localparam int HEALTH_W = 2;
	localparam logic [HEALTH_W-1:0] HEALTH_MAX = 2'd3;

endpackage

// ==== hw/video_pkg.sv ====
// video layout: fixed 8x6 tile map stored row-major, address = row*MAP_COLS + col, 4-bit tile codes
package video_pkg;

	// tile map geometry
	localparam int MAP_COLS   = 8;
	localparam int MAP_ROWS   = 6;
	localparam int TILE_COUNT = MAP_COLS * MAP_ROWS;

	// tile memory address and word width
	localparam int ADDR_W = 6;
	localparam int TILE_W = 4;

	// border tile per background, indexed by background id
	localparam logic [TILE_W-1:0] WALL_CODE [4] = '{
		4'h1,
		4'h5,
		4'h9,
		4'hC
	};

	// interior tile per background
	localparam logic [TILE_W-1:0] FLOOR_CODE [4] = '{
		4'h2,
		4'h6,
		4'hA,
		4'hD
	};

endpackage

// ==== hw/key_events.sv ====
// keydown detector: one keycode at a time, a key must change to fire again; pulses lag keycode by one cycle
module key_events
(
	input  logic       Clk,
	input  logic       arst_n,
	input  logic [7:0] keycode,
	output logic       sel_press,
	output logic       up_press,
	output logic       down_press
);

	logic [7:0] prev_key;
	logic       new_key;
	logic       is_up;
	logic       is_down;

	// a key counts only in the cycle it first shows up
	assign new_key = (keycode != prev_key);

	// letter and arrow layouts both map onto up and down
	assign is_up = (keycode == game_pkg::KEY_UP_W) ||
		(keycode == game_pkg::KEY_UP_ARROW);
	assign is_down = (keycode == game_pkg::KEY_DOWN_S) ||
		(keycode == game_pkg::KEY_DOWN_ARROW);

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prev_key   <= 8'h00;
			sel_press  <= 1'b0;
			up_press   <= 1'b0;
			down_press <= 1'b0;
		end
		else
		begin
			prev_key   <= keycode;
			sel_press  <= new_key && (keycode == game_pkg::KEY_SELECT);
			up_press   <= new_key && is_up;
			down_press <= new_key && is_down;
		end
	end

endmodule

// ==== hw/hit_referee.sv ====
// health referee: hits count only while round_active, one win pulse per round, blue wins a tie
module hit_referee
(
	input  logic Clk,
	input  logic arst_n,
	input  logic round_start,
	input  logic round_active,
	input  logic hit_blue,
	input  logic hit_red,
	output logic blue_wins,
	output logic red_wins
);

	logic [game_pkg::HEALTH_W-1:0] health_blue;
	logic [game_pkg::HEALTH_W-1:0] health_red;
	logic                          decided;
	logic                          blue_down;
	logic                          red_down;
	logic                          hit_b_ok;
	logic                          hit_r_ok;

	// hits are ignored outside a live round or after a winner is known
	assign hit_b_ok = hit_blue && round_active && !decided;
	assign hit_r_ok = hit_red && round_active && !decided;

	// this hit takes the last health point
	assign blue_down = hit_b_ok && (health_blue == 1);
	assign red_down  = hit_r_ok && (health_red == 1);

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			health_blue <= game_pkg::HEALTH_MAX;
			health_red  <= game_pkg::HEALTH_MAX;
			decided     <= 1'b0;
			blue_wins   <= 1'b0;
			red_wins    <= 1'b0;
		end
		else
		begin
			// pulses by default
			blue_wins <= 1'b0;
			red_wins  <= 1'b0;
			if (round_start)
			begin
				health_blue <= game_pkg::HEALTH_MAX;
				health_red  <= game_pkg::HEALTH_MAX;
				decided     <= 1'b0;
			end
			else
			begin
				// saturate at zero
				if (hit_b_ok && (health_blue != '0))
					health_blue <= health_blue - 1'b1;
				if (hit_r_ok && (health_red != '0))
					health_red <= health_red - 1'b1;
				// red down means blue wins, and blue takes a simultaneous knockout
				blue_wins <= red_down;
				red_wins  <= blue_down && !red_down;
				if (red_down || blue_down)
					decided <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/game_state.sv ====
// game flow FSM: presses are ignored while a background loads; a win beats reset_round in the same cycle
module game_state
(
	input  logic                          Clk,
	input  logic                          arst_n,
	input  logic                          sel_press,
	input  logic                          up_press,
	input  logic                          down_press,
	input  logic                          blue_wins,
	input  logic                          red_wins,
	input  logic                          reset_round,
	input  logic                          busy,
	output game_pkg::game_state_t         state,
	output logic [game_pkg::BG_W-1:0]     bg_sel,
	output logic                          load_req,
	output logic                          round_start,
	output logic                          round_active
);

	game_pkg::game_state_t next_state;
	logic                  accept;
	logic                  sel_ok;
	logic                  up_ok;
	logic                  down_ok;
	logic                  entering;

	// a request just issued counts as a load in progress
	assign accept  = !busy && !load_req;
	assign sel_ok  = sel_press && accept;
	assign up_ok   = up_press && accept;
	assign down_ok = down_press && accept;

	assign round_active = (state == game_pkg::Round_Started);
	assign entering     = (next_state != state);

	always_comb
	begin
		next_state = state;
		unique case (state)
			game_pkg::Menu:
				if (sel_ok)
					next_state = game_pkg::Round_Paused;
			game_pkg::Round_Paused:
				if (sel_ok)
					next_state = game_pkg::Round_Started;
			game_pkg::Round_Started:
			begin
				// win first, then round reset
				if (blue_wins)
					next_state = game_pkg::Blue_Wins;
				else if (red_wins)
					next_state = game_pkg::Red_Wins;
				else if (reset_round)
					next_state = game_pkg::Round_Paused;
			end
			game_pkg::Blue_Wins,
			game_pkg::Red_Wins:
				if (sel_ok)
					next_state = game_pkg::Menu;
			default:
				next_state = game_pkg::Menu;
		endcase
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state       <= game_pkg::Menu;
			bg_sel      <= game_pkg::MAP_FIRST;
			load_req    <= 1'b0;
			round_start <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// new background on entry to paused or a win screen
			load_req <= entering && ((next_state == game_pkg::Round_Paused) ||
				(next_state == game_pkg::Blue_Wins) ||
				(next_state == game_pkg::Red_Wins));
			round_start <= entering && (next_state == game_pkg::Round_Paused);

			if (entering && (next_state == game_pkg::Blue_Wins))
				bg_sel <= game_pkg::BG_BLUE_WIN;
			else if (entering && (next_state == game_pkg::Red_Wins))
				bg_sel <= game_pkg::BG_RED_WIN;
			else if (entering && (next_state == game_pkg::Menu))
				bg_sel <= game_pkg::MAP_FIRST;
			else if ((state == game_pkg::Menu) && !entering)
			begin
				// map choice saturates at both ends
				if (up_ok && (bg_sel != game_pkg::MAP_LAST))
					bg_sel <= bg_sel + 1'b1;
				else if (down_ok && (bg_sel != game_pkg::MAP_FIRST))
					bg_sel <= bg_sel - 1'b1;
			end
		end
	end

endmodule

// ==== hw/background_loader.sv ====
// tile map writer: one map per load_req, load_req while busy is dropped, words held stable until accepted
module background_loader
(
	input  logic                              Clk,
	input  logic                              arst_n,
	input  logic                              load_req,
	input  logic [game_pkg::BG_W-1:0]         bg_sel,
	input  logic                              tile_ready,
	output logic                              busy,
	output logic                              tile_valid,
	output logic [video_pkg::ADDR_W-1:0]      tile_addr,
	output logic [video_pkg::TILE_W-1:0]      tile_data
);

	logic                             loading;
	logic [game_pkg::BG_W-1:0]        bg_reg;
	logic [video_pkg::ADDR_W-1:0]     col;
	logic [video_pkg::ADDR_W-1:0]     row;
	logic                             on_ring;
	logic                             xfer;
	logic                             last_word;

	assign busy       = loading;
	assign tile_valid = loading;

	assign xfer      = loading && tile_ready;
	assign last_word = (tile_addr == video_pkg::ADDR_W'(video_pkg::TILE_COUNT - 1));

	// row-major map position of the current word
	assign col = tile_addr % video_pkg::ADDR_W'(video_pkg::MAP_COLS);
	assign row = tile_addr / video_pkg::ADDR_W'(video_pkg::MAP_COLS);

	// outer ring gets the wall tile
	assign on_ring = (col == '0) ||
		(col == video_pkg::ADDR_W'(video_pkg::MAP_COLS - 1)) ||
		(row == '0) ||
		(row == video_pkg::ADDR_W'(video_pkg::MAP_ROWS - 1));

	assign tile_data = on_ring ? video_pkg::WALL_CODE[bg_reg] : video_pkg::FLOOR_CODE[bg_reg];

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			loading   <= 1'b0;
			tile_addr <= '0;
			bg_reg    <= game_pkg::MAP_FIRST;
		end
		else if (!loading)
		begin
			if (load_req)
			begin
				loading   <= 1'b1;
				tile_addr <= '0;
				bg_reg    <= bg_sel;
			end
		end
		else if (xfer)
		begin
			if (last_word)
			begin
				loading   <= 1'b0;
				tile_addr <= '0;
			end
			else
				tile_addr <= tile_addr + 1'b1;
		end
	end

endmodule

// ==== hw/game_top.sv ====
// game core top: hits arrive as external pulses, tile memory sits outside behind the valid/ready stream
module game_top
(
	input  logic                              Clk,
	input  logic                              arst_n,
	input  logic [7:0]                        keycode,
	input  logic                              hit_blue,
	input  logic                              hit_red,
	input  logic                              reset_round,
	input  logic                              tile_ready,
	output game_pkg::game_state_t             state,
	output logic [game_pkg::BG_W-1:0]         bg_sel,
	output logic                              tile_valid,
	output logic [video_pkg::ADDR_W-1:0]      tile_addr,
	output logic [video_pkg::TILE_W-1:0]      tile_data,
	output logic                              busy
);

	// key events
	logic sel_press;
	logic up_press;
	logic down_press;

	// referee handshake
	logic blue_wins;
	logic red_wins;
	logic round_start;
	logic round_active;

	logic load_req;

	key_events u_key_events
	(
		.Clk        (Clk),
		.arst_n     (arst_n),
		.keycode    (keycode),
		.sel_press  (sel_press),
		.up_press   (up_press),
		.down_press (down_press)
	);

	hit_referee u_hit_referee
	(
		.Clk          (Clk),
		.arst_n       (arst_n),
		.round_start  (round_start),
		.round_active (round_active),
		.hit_blue     (hit_blue),
		.hit_red      (hit_red),
		.blue_wins    (blue_wins),
		.red_wins     (red_wins)
	);

	game_state u_game_state
	(
		.Clk          (Clk),
		.arst_n       (arst_n),
		.sel_press    (sel_press),
		.up_press     (up_press),
		.down_press   (down_press),
		.blue_wins    (blue_wins),
		.red_wins     (red_wins),
		.reset_round  (reset_round),
		.busy         (busy),
		.state        (state),
		.bg_sel       (bg_sel),
		.load_req     (load_req),
		.round_start  (round_start),
		.round_active (round_active)
	);

	background_loader u_background_loader
	(
		.Clk        (Clk),
		.arst_n     (arst_n),
		.load_req   (load_req),
		.bg_sel     (bg_sel),
		.tile_ready (tile_ready),
		.busy       (busy),
		.tile_valid (tile_valid),
		.tile_addr  (tile_addr),
		.tile_data  (tile_data)
	);

endmodule

// ==== dv/game_assertions.sv ====
// bound into game_top so it sees both the FSM outputs and the tile stream; checks are off during reset
module game_assertions
(
	input logic                          Clk,
	input logic                          arst_n,
	input game_pkg::game_state_t         state,
	input logic                          load_req,
	input logic                          busy,
	input logic                          round_active,
	input logic                          blue_wins,
	input logic                          red_wins,
	input logic                          tile_valid,
	input logic                          tile_ready,
	input logic [video_pkg::ADDR_W-1:0]  tile_addr,
	input logic [video_pkg::TILE_W-1:0]  tile_data
);

	// a new request never lands on a running load
	no_req_while_busy: assert property (@(posedge Clk) disable iff (!arst_n)
		!(load_req && busy))
		else $error("load_req raised while the loader is busy");

	// stalled word holds until accepted
	hold_under_stall: assert property (@(posedge Clk) disable iff (!arst_n)
		(tile_valid && !tile_ready) |=> (tile_valid && $stable(tile_addr) && $stable(tile_data)))
		else $error("tile word changed while stalled");

	// a win pulse in a live round ends it on the matching win screen
	blue_win_entry: assert property (@(posedge Clk) disable iff (!arst_n)
		(round_active && blue_wins) |=> (state == game_pkg::Blue_Wins))
		else $error("blue win pulse did not lead to the blue win screen");

	red_win_entry: assert property (@(posedge Clk) disable iff (!arst_n)
		(round_active && red_wins) |=> (state == game_pkg::Red_Wins))
		else $error("red win pulse did not lead to the red win screen");

endmodule

// ==== dv/tb_game.sv ====
// directed testbench for game_top; tile_ready stalls come from a fixed seed, the tile memory is a simple log
module tb_game;

	// six map loads at a generous stall budget, plus key presses and hits
	localparam int WATCHDOG_CYCLES = 6 * 10 * video_pkg::TILE_COUNT + 1120;

	logic                             Clk;
	logic                             arst_n;
	logic [7:0]                       keycode;
	logic                             hit_blue;
	logic                             hit_red;
	logic                             reset_round;
	logic                             tile_ready;
	game_pkg::game_state_t            state;
	logic [game_pkg::BG_W-1:0]        bg_sel;
	logic                             tile_valid;
	logic [video_pkg::ADDR_W-1:0]     tile_addr;
	logic [video_pkg::TILE_W-1:0]     tile_data;
	logic                             busy;

	int     errors;
	string  test_name;
	integer seed;
	bit     stall_on;
	int     rec_addr[$];
	int     rec_data[$];
	int     map_ref[$];

	game_top dut
	(
		.Clk         (Clk),
		.arst_n      (arst_n),
		.keycode     (keycode),
		.hit_blue    (hit_blue),
		.hit_red     (hit_red),
		.reset_round (reset_round),
		.tile_ready  (tile_ready),
		.state       (state),
		.bg_sel      (bg_sel),
		.tile_valid  (tile_valid),
		.tile_addr   (tile_addr),
		.tile_data   (tile_data),
		.busy        (busy)
	);

	bind game_top game_assertions u_game_assertions
	(
		.Clk          (Clk),
		.arst_n       (arst_n),
		.state        (state),
		.load_req     (load_req),
		.busy         (busy),
		.round_active (round_active),
		.blue_wins    (blue_wins),
		.red_wins     (red_wins),
		.tile_valid   (tile_valid),
		.tile_ready   (tile_ready),
		.tile_addr    (tile_addr),
		.tile_data    (tile_data)
	);

	initial
	begin
		Clk = 1'b0;
		forever
			#10 Clk = ~Clk;
	end

	// tile memory model, logs every accepted word in arrival order
	always @(posedge Clk)
	begin
		if (arst_n && tile_valid && tile_ready)
		begin
			rec_addr.push_back(tile_addr);
			rec_data.push_back(tile_data);
		end
	end

	// ready source, roughly half the cycles stall when enabled
	always @(posedge Clk)
	begin
		if (stall_on)
			tile_ready <= ($random(seed) & 1) != 0;
		else
			tile_ready <= 1'b1;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected !== actual)
		begin
			errors++;
			$display("error %s (%s): expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	// border ring gets the wall code, the rest the floor code
	function automatic int expected_tile(input int bg, input int addr);
		int col;
		int row;
		col = addr % video_pkg::MAP_COLS;
		row = addr / video_pkg::MAP_COLS;
		if (col == 0 || col == video_pkg::MAP_COLS - 1 || row == 0 || row == video_pkg::MAP_ROWS - 1)
			return int'(video_pkg::WALL_CODE[bg]);
		return int'(video_pkg::FLOOR_CODE[bg]);
	endfunction

	// key held for several cycles, then released
	task automatic press_key(input logic [7:0] code);
		@(posedge Clk);
		keycode <= code;
		repeat (4) @(posedge Clk);
		keycode <= 8'h00;
		repeat (2) @(posedge Clk);
		@(negedge Clk);
	endtask

	task automatic strike(input bit on_red);
		@(posedge Clk);
		hit_red  <= on_red;
		hit_blue <= !on_red;
		@(posedge Clk);
		hit_red  <= 1'b0;
		hit_blue <= 1'b0;
		repeat (2) @(posedge Clk);
		@(negedge Clk);
	endtask

	task automatic pulse_reset_round;
		@(posedge Clk);
		reset_round <= 1'b1;
		@(posedge Clk);
		reset_round <= 1'b0;
		repeat (2) @(posedge Clk);
		@(negedge Clk);
	endtask

	// busy rise then fall, the watchdog covers a load that never ends
	task automatic wait_load;
		while (!busy)
			@(negedge Clk);
		while (busy)
			@(negedge Clk);
	endtask

	task automatic clear_record;
		rec_addr.delete();
		rec_data.delete();
	endtask

	task automatic check_map(input int bg);
		check_value("tile count", video_pkg::TILE_COUNT, rec_addr.size());
		foreach (rec_addr[i])
		begin
			check_value("tile addr", i, rec_addr[i]);
			check_value("tile data", expected_tile(bg, i), rec_data[i]);
		end
	endtask

	task automatic menu_navigation;
		test_name = "menu_navigation";
		check_value("state after reset", game_pkg::Menu, state);
		check_value("bg_sel after reset", game_pkg::MAP_FIRST, bg_sel);
		check_value("busy after reset", 0, busy);
		check_value("tile_valid after reset", 0, tile_valid);
		press_key(game_pkg::KEY_UP_W);
		check_value("bg_sel after held up", game_pkg::MAP_LAST, bg_sel);
		press_key(game_pkg::KEY_UP_ARROW);
		check_value("bg_sel up saturates", game_pkg::MAP_LAST, bg_sel);
		press_key(game_pkg::KEY_DOWN_S);
		check_value("bg_sel after down", game_pkg::MAP_FIRST, bg_sel);
		press_key(game_pkg::KEY_DOWN_ARROW);
		check_value("bg_sel down saturates", game_pkg::MAP_FIRST, bg_sel);
	endtask

	task automatic round_start_load;
		test_name = "round_start_load";
		press_key(game_pkg::KEY_UP_ARROW);
		check_value("chosen map", game_pkg::MAP_LAST, bg_sel);
		clear_record();
		press_key(game_pkg::KEY_SELECT);
		check_value("state after select", game_pkg::Round_Paused, state);
		check_value("busy during load", 1, busy);
		// presses during the load must be dropped
		press_key(game_pkg::KEY_SELECT);
		press_key(game_pkg::KEY_DOWN_S);
		check_value("state while busy", game_pkg::Round_Paused, state);
		check_value("bg_sel while busy", game_pkg::MAP_LAST, bg_sel);
		wait_load();
		check_map(game_pkg::MAP_LAST);
		map_ref = rec_data;
	endtask

	task automatic back_pressure;
		test_name = "back_pressure";
		press_key(game_pkg::KEY_SELECT);
		check_value("round started", game_pkg::Round_Started, state);
		clear_record();
		stall_on = 1'b1;
		pulse_reset_round();
		check_value("paused after reset", game_pkg::Round_Paused, state);
		wait_load();
		stall_on = 1'b0;
		check_map(game_pkg::MAP_LAST);
		check_value("last addr before busy fall", video_pkg::TILE_COUNT - 1, rec_addr[$]);
		foreach (map_ref[i])
			check_value("stalled map vs reference", map_ref[i], rec_data[i]);
	endtask

	task automatic hits_and_win;
		test_name = "hits_and_win";
		// paused round ignores hits
		repeat (game_pkg::HEALTH_MAX) strike(1'b1);
		check_value("state after paused hits", game_pkg::Round_Paused, state);
		press_key(game_pkg::KEY_SELECT);
		check_value("round started", game_pkg::Round_Started, state);
		repeat (game_pkg::HEALTH_MAX - 1) strike(1'b1);
		check_value("state before last hit", game_pkg::Round_Started, state);
		clear_record();
		strike(1'b1);
		check_value("state after knockout", game_pkg::Blue_Wins, state);
		check_value("win screen", game_pkg::BG_BLUE_WIN, bg_sel);
		wait_load();
		check_map(game_pkg::BG_BLUE_WIN);
	endtask

	task automatic round_reset_return;
		test_name = "round_reset_return";
		press_key(game_pkg::KEY_SELECT);
		check_value("back in menu", game_pkg::Menu, state);
		check_value("menu map", game_pkg::MAP_FIRST, bg_sel);
		clear_record();
		press_key(game_pkg::KEY_SELECT);
		wait_load();
		check_map(game_pkg::MAP_FIRST);
		press_key(game_pkg::KEY_SELECT);
		repeat (game_pkg::HEALTH_MAX - 1) strike(1'b0);
		repeat (game_pkg::HEALTH_MAX - 1) strike(1'b1);
		pulse_reset_round();
		check_value("paused after reset", game_pkg::Round_Paused, state);
		wait_load();
		press_key(game_pkg::KEY_SELECT);
		// both players must be back at full health here
		repeat (game_pkg::HEALTH_MAX - 1) strike(1'b0);
		repeat (game_pkg::HEALTH_MAX - 1) strike(1'b1);
		check_value("health refilled", game_pkg::Round_Started, state);
		clear_record();
		strike(1'b0);
		check_value("state after knockout", game_pkg::Red_Wins, state);
		check_value("win screen", game_pkg::BG_RED_WIN, bg_sel);
		wait_load();
		check_map(game_pkg::BG_RED_WIN);
		press_key(game_pkg::KEY_SELECT);
		check_value("menu after win", game_pkg::Menu, state);
		check_value("menu map after win", game_pkg::MAP_FIRST, bg_sel);
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge Clk);
		$display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		errors      = 0;
		seed        = 3986;
		stall_on    = 1'b0;
		arst_n      = 1'b0;
		keycode     = 8'h00;
		hit_blue    = 1'b0;
		hit_red     = 1'b0;
		reset_round = 1'b0;
		tile_ready  = 1'b1;
		repeat (8) @(posedge Clk);
		arst_n <= 1'b1;
		@(negedge Clk);
		menu_navigation();
		round_start_load();
		back_pressure();
		hits_and_win();
		round_reset_return();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/game_pkg.sv
hw/video_pkg.sv
hw/key_events.sv
hw/hit_referee.sv
hw/game_state.sv
hw/background_loader.sv
hw/game_top.sv
dv/game_assertions.sv
dv/tb_game.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and passes only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_game -f vlog.f -o sim_tb_game \
	|| { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/sim_tb_game)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1
